/* all.f */
src/anticPkg.sv
src/dmaCtlRegs.sv
src/dlistSequencer.sv
src/blankLineGen.sv
src/mapPixelShifter.sv
src/anticTranslate.sv
testbench/anticTranslate_checker.sv
testbench/anticTranslate_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the translator testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module anticTranslate_tb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "Everything OK" sim.log; then
  exit 0
fi
exit 1

/* src/anticPkg.sv */
/* Shared codes, mode numbers and instruction fields for the display-list translator.
   Imported by every module of the design. */
package anticPkg;

  // Code sent to the colour chip on each Fphi0 cycle
  typedef logic [3:0] anCode_t;

  localparam anCode_t anNoTx       = 4'b1000;
  localparam anCode_t anBgColor    = 4'b0000;
  localparam anCode_t anPlayfield0 = 4'b0100;
  localparam anCode_t anPlayfield1 = 4'b0101;
  localparam anCode_t anPlayfield2 = 4'b0110;

  // Instruction mode numbers found in bits 3:0
  localparam logic [3:0] modeBlank     = 4'd0;
  localparam logic [3:0] modeJump      = 4'd1;
  localparam logic [3:0] modeMapDouble = 4'd13;
  localparam logic [3:0] modeMapSingle = 4'd14;

  // Bit 6 is LMS for map modes and wait-for-vblank for jumps
  localparam int LmsBit = 6;
  localparam int JvbBit = 6;

  typedef enum logic [1:0] {
    pfNone     = 2'd0,
    pfNarrow   = 2'd1,
    pfStandard = 2'd2,
    pfWide     = 2'd3
  } pfWidth_t;

  // Screen bytes fetched per mode line for each playfield width
  localparam logic [6:0] BytesNarrow   = 7'd32;
  localparam logic [6:0] BytesStandard = 7'd40;
  localparam logic [6:0] BytesWide     = 7'd48;

  localparam int ScanLinesPerModeLine = 8;

endpackage

/* src/anticTranslate.sv */
/* Top level of the display-list translator: APB control register, sequencer and the
   two line engines, merged into a single code stream for the colour chip. */
`timescale 1ns/1ps

module anticTranslate
  import anticPkg::*;
#(
  parameter int         ScanWidth   = 320,
  parameter logic [7:0] DmaCtlReset = {6'd0, pfStandard}
) (
  input  logic        Fphi0,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [7:0]  pwdata,
  output logic [7:0]  prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic [7:0]  ir,
  input  logic        irRdy,
  output logic        irReq,
  input  logic        vblank,
  output logic        dlistLoad,
  output logic        dlistEnd,
  output logic [15:0] dlistAddr,
  output logic        msrLoad,
  output logic [15:0] msrAddr,
  input  logic [7:0]  msrData,
  input  logic        dataRdy,
  output logic        dataReq,
  output anCode_t     an
);

  pfWidth_t   playfieldWidth;
  logic       blankStart;
  logic       blankDone;
  logic [2:0] blankLines;
  logic       mapStart;
  logic       mapDone;
  logic       pixelDouble;
  anCode_t    blankAn;
  anCode_t    mapAn;

  dmaCtlRegs #(.DmaCtlReset(DmaCtlReset)) u_regs (
    .Fphi0, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .playfieldWidth
  );

  dlistSequencer u_seq (
    .Fphi0, .rst, .ir, .irRdy, .vblank, .blankDone, .mapDone, .irReq,
    .dlistLoad, .dlistEnd, .msrLoad, .dlistAddr, .msrAddr,
    .blankStart, .blankLines, .mapStart, .pixelDouble
  );

  blankLineGen #(.ScanWidth(ScanWidth)) u_blank (
    .Fphi0, .rst, .blankStart, .blankLines, .an(blankAn), .blankDone
  );

  mapPixelShifter u_map (
    .Fphi0, .rst, .mapStart, .pixelDouble, .playfieldWidth, .msrData,
    .dataRdy, .dataReq, .an(mapAn), .mapDone
  );

  // Engines run one at a time and idle at anNoTx
  assign an = (blankAn != anNoTx) ? blankAn : mapAn;

endmodule

/* src/blankLineGen.sv */
/* Blank-line engine: emits background codes for every pixel of the requested
   number of mode lines, then pulses blankDone. */
`timescale 1ns/1ps

module blankLineGen
  import anticPkg::*;
#(
  parameter int ScanWidth = 320
) (
  input  logic       Fphi0,
  input  logic       rst,
  input  logic       blankStart,
  input  logic [2:0] blankLines,
  output anCode_t    an,
  output logic       blankDone
);

  localparam int MaxCodes = 8 * ScanLinesPerModeLine * ScanWidth;
  localparam int CountW   = $clog2(MaxCodes + 1);

  logic [CountW-1:0] remaining;
  logic [CountW-1:0] totalCodes;

  assign totalCodes = CountW'((int'(blankLines) + 1) * ScanLinesPerModeLine * ScanWidth);

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      remaining <= '0;
      blankDone <= 1'b0;
    end else begin
      // Done lands one cycle after the last background code
      blankDone <= (remaining == CountW'(1));
      if (blankStart) begin
        remaining <= totalCodes;
      end else if (remaining != '0) begin
        remaining <= remaining - 1'b1;
      end
    end
  end

  assign an = (remaining != '0) ? anBgColor : anNoTx;

endmodule

/* src/dlistSequencer.sv */
/* Display-list controller: fetches instruction and operand bytes, runs jumps and LMS
   loads, and hands blank and map instructions to the line engines. */
`timescale 1ns/1ps

module dlistSequencer
  import anticPkg::*;
(
  input  logic        Fphi0,
  input  logic        rst,
  input  logic [7:0]  ir,
  input  logic        irRdy,
  input  logic        vblank,
  input  logic        blankDone,
  input  logic        mapDone,
  output logic        irReq,
  output logic        dlistLoad,
  output logic        dlistEnd,
  output logic        msrLoad,
  output logic [15:0] dlistAddr,
  output logic [15:0] msrAddr,
  output logic        blankStart,
  output logic [2:0]  blankLines,
  output logic        mapStart,
  output logic        pixelDouble
);

  typedef enum logic [3:0] {
    sStart, sWaitIr, sJumpLo, sJumpHi, sJumpLoad, sVblank,
    sLmsLo, sLmsHi, sWaitBlank, sWaitMap
  } seqState_t;

  seqState_t  state;
  logic [3:0] mode;
  logic       jvb;
  logic [7:0] addrLo;

  assign mode = ir[3:0];

  // All strobes are registered and default low, so each lasts a single cycle
  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      state      <= sStart;
      jvb        <= 1'b0;
      irReq      <= 1'b0;
      dlistLoad  <= 1'b0;
      dlistEnd   <= 1'b0;
      msrLoad    <= 1'b0;
      blankStart <= 1'b0;
      mapStart   <= 1'b0;
    end else begin
      irReq      <= 1'b0;
      dlistLoad  <= 1'b0;
      dlistEnd   <= 1'b0;
      msrLoad    <= 1'b0;
      blankStart <= 1'b0;
      mapStart   <= 1'b0;
      case (state)
        sStart: begin
          irReq <= 1'b1;
          state <= sWaitIr;
        end
        sWaitIr: begin
          if (irRdy) begin
            if (mode == modeBlank) begin
              blankStart <= 1'b1;
              state      <= sWaitBlank;
            end else if (mode == modeJump) begin
              jvb   <= ir[JvbBit];
              irReq <= 1'b1;
              state <= sJumpLo;
            end else if (mode == modeMapDouble || mode == modeMapSingle) begin
              if (ir[LmsBit]) begin
                irReq <= 1'b1;
                state <= sLmsLo;
              end else begin
                mapStart <= 1'b1;
                state    <= sWaitMap;
              end
            end else begin
              // Unsupported mode, drop it and fetch the next instruction
              irReq <= 1'b1;
            end
          end
        end
        sJumpLo, sLmsLo: begin
          if (irRdy) begin
            irReq <= 1'b1;
            state <= (state == sJumpLo) ? sJumpHi : sLmsHi;
          end
        end
        sJumpHi: begin
          if (irRdy) begin
            dlistLoad <= 1'b1;
            dlistEnd  <= jvb;
            state     <= sJumpLoad;
          end
        end
        sJumpLoad: begin
          if (jvb) begin
            state <= sVblank;
          end else begin
            irReq <= 1'b1;
            state <= sWaitIr;
          end
        end
        sVblank: begin
          if (vblank) begin
            jvb   <= 1'b0;
            irReq <= 1'b1;
            state <= sWaitIr;
          end
        end
        sLmsHi: begin
          if (irRdy) begin
            msrLoad  <= 1'b1;
            mapStart <= 1'b1;
            state    <= sWaitMap;
          end
        end
        sWaitBlank, sWaitMap: begin
          if ((state == sWaitBlank && blankDone) || (state == sWaitMap && mapDone)) begin
            irReq <= 1'b1;
            state <= sWaitIr;
          end
        end
        default: state <= sStart;
      endcase
    end
  end

  // Operand bytes and instruction fields
  always_ff @(posedge Fphi0) begin
    if ((state == sJumpLo || state == sLmsLo) && irRdy) begin
      addrLo <= ir;
    end
    if (state == sJumpHi && irRdy) begin
      dlistAddr <= {ir, addrLo};
    end
    if (state == sLmsHi && irRdy) begin
      msrAddr <= {ir, addrLo};
    end
    if (state == sWaitIr && irRdy) begin
      blankLines  <= ir[6:4];
      pixelDouble <= (mode == modeMapDouble);
    end
  end

endmodule

/* src/dmaCtlRegs.sv */
/* APB slave holding the DMA control register; bits 1:0 select the playfield width
   used by the map modes. Zero wait states, bad addresses answer with pslverr. */
`timescale 1ns/1ps

module dmaCtlRegs
  import anticPkg::*;
#(
  parameter logic [7:0] DmaCtlReset = {6'd0, pfStandard}
) (
  input  logic       Fphi0,
  input  logic       rst,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  logic [3:0] paddr,
  input  logic [7:0] pwdata,
  output logic [7:0] prdata,
  output logic       pready,
  output logic       pslverr,
  output pfWidth_t   playfieldWidth
);

  logic [7:0] dmaCtl;
  logic       access;
  logic       addrOk;

  assign access = psel && penable;
  // Only the control register at offset 0 exists
  assign addrOk = (paddr == 4'd0);

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      dmaCtl <= DmaCtlReset;
    end else if (access && pwrite && addrOk) begin
      dmaCtl <= pwdata;
    end
  end

  assign prdata  = (psel && addrOk) ? dmaCtl : 8'h00;
  assign pready  = 1'b1;
  assign pslverr = access && !addrOk;

  assign playfieldWidth = pfWidth_t'(dmaCtl[1:0]);

endmodule

/* src/mapPixelShifter.sv */
/* Map-mode engine: fetches one mode line of screen bytes and shifts each out as four
   2-bit pixels, MSB pair first, optionally doubled. One byte is prefetched. */
`timescale 1ns/1ps

module mapPixelShifter
  import anticPkg::*;
(
  input  logic       Fphi0,
  input  logic       rst,
  input  logic       mapStart,
  input  logic       pixelDouble,
  input  pfWidth_t   playfieldWidth,
  input  logic [7:0] msrData,
  input  logic       dataRdy,
  output logic       dataReq,
  output anCode_t    an,
  output logic       mapDone
);

  logic       active;
  logic       doubleMode;
  logic       pending;
  logic       bufValid;
  logic       loadShift;
  logic [6:0] reqLeft;
  logic [6:0] lineBytes;
  logic [3:0] pixLeft;
  logic [7:0] bufByte;
  logic [7:0] shiftByte;

  always_comb begin
    case (playfieldWidth)
      pfNarrow:   lineBytes = BytesNarrow;
      pfStandard: lineBytes = BytesStandard;
      pfWide:     lineBytes = BytesWide;
      default:    lineBytes = 7'd0;
    endcase
  end

  // Ask for the next byte as soon as the prefetch slot is free
  assign dataReq   = active && (reqLeft != 7'd0) && !pending && !bufValid;
  // Shifter takes a new byte in its last pixel cycle or when empty
  assign loadShift = (pixLeft <= 4'd1) && (bufValid || dataRdy);
  assign mapDone   = active && (reqLeft == 7'd0) && !pending && !bufValid && (pixLeft == 4'd0);

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      active     <= 1'b0;
      doubleMode <= 1'b0;
      reqLeft    <= 7'd0;
      pending    <= 1'b0;
      bufValid   <= 1'b0;
      pixLeft    <= 4'd0;
    end else begin
      if (mapStart) begin
        active     <= 1'b1;
        doubleMode <= pixelDouble;
        reqLeft    <= lineBytes;
      end else if (mapDone) begin
        active <= 1'b0;
      end
      if (dataReq) begin
        pending <= 1'b1;
        reqLeft <= reqLeft - 7'd1;
      end else if (dataRdy) begin
        pending <= 1'b0;
      end
      if (pixLeft != 4'd0) begin
        pixLeft <= pixLeft - 4'd1;
      end
      if (loadShift) begin
        pixLeft  <= doubleMode ? 4'd8 : 4'd4;
        bufValid <= 1'b0;
      end else if (dataRdy) begin
        bufValid <= 1'b1;
      end
    end
  end

  always_ff @(posedge Fphi0) begin
    if (loadShift) begin
      shiftByte <= bufValid ? bufByte : msrData;
    end else if (pixLeft != 4'd0 && (!doubleMode || pixLeft[0])) begin
      shiftByte <= {shiftByte[5:0], 2'b00};
    end
    if (dataRdy && !loadShift) begin
      bufByte <= msrData;
    end
  end

  always_comb begin
    an = anNoTx;
    if (pixLeft != 4'd0) begin
      case (shiftByte[7:6])
        2'd0:    an = anBgColor;
        2'd1:    an = anPlayfield0;
        2'd2:    an = anPlayfield1;
        default: an = anPlayfield2;
      endcase
    end
  end

endmodule

/* testbench/anticTranslate_checker.sv */
/* Protocol assertions for the translator, bound to the top level.
   Pulses must be single cycle and the code stream idle in reset. */
`timescale 1ns/1ps

module anticTranslate_checker
  import anticPkg::*;
(
  input logic    Fphi0,
  input logic    rst,
  input logic    irReq,
  input logic    dataReq,
  input logic    dlistLoad,
  input anCode_t an
);

  irReqPulse: assert property (@(posedge Fphi0) disable iff (rst) irReq |=> !irReq)
    else $error("irReq held longer than one cycle");

  dataReqPulse: assert property (@(posedge Fphi0) disable iff (rst) dataReq |=> !dataReq)
    else $error("dataReq held longer than one cycle");

  // A jump never overlaps a visible code
  loadQuiet: assert property (@(posedge Fphi0) disable iff (rst) dlistLoad |-> an == anNoTx)
    else $error("dlistLoad while codes are emitted");

  resetIdle: assert property (@(posedge Fphi0) rst |-> an == anNoTx)
    else $error("code emitted during reset");

endmodule

bind anticTranslate anticTranslate_checker u_chk (
  .Fphi0, .rst, .irReq, .dataReq, .dlistLoad, .an
);

/* testbench/anticTranslate_tb.sv */
/* Testbench for the display-list translator. Reads test records from the data file,
   serves instruction and screen bytes with random latency and checks the code stream. */
`timescale 1ns/1ps

module anticTranslate_tb
  import anticPkg::*;
();

  logic        Fphi0 = 1'b0;
  logic        rst = 1'b1;
  logic        psel = 1'b0;
  logic        penable = 1'b0;
  logic        pwrite = 1'b0;
  logic [3:0]  paddr = 4'd0;
  logic [7:0]  pwdata = 8'd0;
  logic [7:0]  prdata;
  logic        pready;
  logic        pslverr;
  logic [7:0]  ir = 8'd0;
  logic        irRdy = 1'b0;
  logic        irReq;
  logic        vblank = 1'b0;
  logic        dlistLoad;
  logic        dlistEnd;
  logic [15:0] dlistAddr;
  logic        msrLoad;
  logic [15:0] msrAddr;
  logic [7:0]  msrData = 8'd0;
  logic        dataRdy = 1'b0;
  logic        dataReq;
  anCode_t     an;

  logic [7:0]  tests [0:127];
  logic [31:0] lfsr = 32'd87777;
  logic [7:0]  irQueue [$];
  anCode_t     codes [$];
  logic [15:0] msrPtr = 16'd0;
  logic [15:0] lastMsr = 16'd0;
  logic [15:0] lastDlist = 16'd0;
  int irWait = 0;
  int dataWait = 0;
  int irReqCount = 0;
  int dataReqCount = 0;
  int msrLoadCount = 0;
  int dlistLoadCount = 0;
  int dlistEndCount = 0;
  int pushed = 0;
  int errors = 0;
  int passed = 0;
  int limitCycles = 0;

  anticTranslate #(.ScanWidth(16)) u_dut (
    .Fphi0, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .pslverr, .ir, .irRdy, .irReq, .vblank, .dlistLoad, .dlistEnd, .dlistAddr,
    .msrLoad, .msrAddr, .msrData, .dataRdy, .dataReq, .an
  );

  always #10 Fphi0 = ~Fphi0;

  // Galois LFSR that is stepped once per random bit
  function automatic int takeBit();
    int b;
    b = int'(lfsr[0]);
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    return b;
  endfunction

  function automatic int drawLatency();
    int hi;
    int lo;
    hi = takeBit();
    lo = takeBit();
    return 1 + 2 * hi + lo;
  endfunction

  // Screen memory content depends on every address bit
  function automatic logic [7:0] screenByte(input logic [15:0] addr);
    return {addr[3:0], addr[7:4]} ^ addr[15:8] ^ 8'h5A;
  endfunction

  function automatic anCode_t colourOf(input logic [1:0] pix);
    case (pix)
      2'd0:    return anBgColor;
      2'd1:    return anPlayfield0;
      2'd2:    return anPlayfield1;
      default: return anPlayfield2;
    endcase
  endfunction

  task automatic reportMismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  // Memory responder and stream monitor run 2 ns after each rising edge
  always begin
    @(posedge Fphi0);
    #2;
    irRdy = 1'b0;
    dataRdy = 1'b0;
    if (!rst) begin
      if (irWait > 0) begin
        irWait = irWait - 1;
        if (irWait == 0) begin
          if (irQueue.size() > 0) begin
            ir = irQueue.pop_front();
            irRdy = 1'b1;
          end else begin
            irWait = 1;
          end
        end
      end
      if (dataWait > 0) begin
        dataWait = dataWait - 1;
        if (dataWait == 0) begin
          msrData = screenByte(msrPtr);
          msrPtr = msrPtr + 16'd1;
          dataRdy = 1'b1;
        end
      end
      if (irReq) begin
        irWait = drawLatency();
        irReqCount++;
      end
      if (dataReq) begin
        dataWait = drawLatency();
        dataReqCount++;
      end
      if (msrLoad) begin
        msrPtr = msrAddr;
        lastMsr = msrAddr;
        msrLoadCount++;
      end
      if (dlistLoad) begin
        lastDlist = dlistAddr;
        dlistLoadCount++;
        if (dlistEnd) begin
          dlistEndCount++;
        end
      end
      if (an != anNoTx) begin
        codes.push_back(an);
      end
    end
  end

  task automatic apbWrite(input logic [3:0] addr, input logic [7:0] data, output logic err);
    @(posedge Fphi0);
    #2;
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge Fphi0);
    #2;
    penable = 1'b1;
    #1;
    err = pslverr;
    if (!pready) reportMismatch("pready low in write access phase");
    @(posedge Fphi0);
    #2;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apbRead(input logic [3:0] addr, output logic [7:0] data, output logic err);
    @(posedge Fphi0);
    #2;
    psel = 1'b1;
    paddr = addr;
    @(posedge Fphi0);
    #2;
    penable = 1'b1;
    #1;
    err = pslverr;
    data = prdata;
    if (!pready) reportMismatch("pready low in read access phase");
    @(posedge Fphi0);
    #2;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic checkApb(input logic [7:0] value, input logic [3:0] badAddr);
    logic       err;
    logic [7:0] rd;
    apbWrite(4'd0, value, err);
    if (err) reportMismatch("pslverr on write to control register");
    apbRead(4'd0, rd, err);
    if (rd != value || err) reportMismatch($sformatf("read back %02h, expected %02h", rd, value));
    apbWrite(badAddr, ~value, err);
    if (!err) reportMismatch("no pslverr on write to bad address");
    apbRead(badAddr, rd, err);
    if (!err) reportMismatch("no pslverr on read from bad address");
    apbRead(4'd0, rd, err);
    if (rd != value) reportMismatch($sformatf("register changed to %02h after bad write", rd));
  endtask

  task automatic runTest(input int idx);
    int          b;
    int          kind;
    int          fileCount;
    int          expCount;
    int          nBytes;
    int          perByte;
    int          dataBase;
    int          msrBase;
    int          dlBase;
    int          endBase;
    int          errBase;
    logic        err;
    logic [7:0]  instr;
    logic [15:0] opAddr;
    logic [7:0]  sb;
    anCode_t     want;
    b = idx * 8;
    kind = int'(tests[b]);
    instr = tests[b + 2];
    opAddr = {tests[b + 4], tests[b + 3]};
    fileCount = int'({tests[b + 5], tests[b + 6]});
    errBase = errors;
    while (irReqCount != pushed + 1) @(posedge Fphi0);
    codes.delete();
    dataBase = dataReqCount;
    msrBase = msrLoadCount;
    dlBase = dlistLoadCount;
    endBase = dlistEndCount;
    if (kind == 0) begin
      checkApb(tests[b + 1], tests[b + 7][3:0]);
    end else begin
      apbWrite(4'd0, tests[b + 1], err);
      if (err) reportMismatch("pslverr on write to control register");
      // Queue the bytes after the responder has finished with this cycle
      #1;
      irQueue.push_back(instr);
      pushed++;
      if (kind == 3 || instr[LmsBit]) begin
        irQueue.push_back(opAddr[7:0]);
        irQueue.push_back(opAddr[15:8]);
        pushed += 2;
      end
      if (kind == 3 && instr[JvbBit]) begin
        while (dlistEndCount == endBase) @(posedge Fphi0);
        repeat (20) @(posedge Fphi0);
        if (irReqCount != pushed) reportMismatch("fetch issued before vblank");
        #2;
        vblank = 1'b1;
      end
      while (irReqCount != pushed + 1) @(posedge Fphi0);
      #2;
      vblank = 1'b0;
    end
    if (kind == 1) begin
      expCount = (int'(instr[6:4]) + 1) * ScanLinesPerModeLine * 16;
      if (expCount != fileCount) reportMismatch("blank count in data file disagrees");
      if (codes.size() != expCount) begin
        reportMismatch($sformatf("%0d blank codes, expected %0d", codes.size(), expCount));
      end
      foreach (codes[i]) begin
        if (codes[i] != anBgColor) reportMismatch($sformatf("code %0d not background", i));
      end
    end else if (kind == 2) begin
      case (tests[b + 1][1:0])
        2'd1:    nBytes = 32;
        2'd2:    nBytes = 40;
        2'd3:    nBytes = 48;
        default: nBytes = 0;
      endcase
      perByte = (instr[3:0] == modeMapDouble) ? 8 : 4;
      expCount = nBytes * perByte;
      if (expCount != fileCount) reportMismatch("map count in data file disagrees");
      if (dataReqCount - dataBase != nBytes) reportMismatch("wrong number of screen fetches");
      if (msrLoadCount - msrBase != 1 || lastMsr != opAddr) reportMismatch("bad msrLoad");
      if (codes.size() != expCount) begin
        reportMismatch($sformatf("%0d map codes, expected %0d", codes.size(), expCount));
      end else begin
        for (int i = 0; i < expCount; i++) begin
          sb = screenByte(opAddr + 16'(i / perByte));
          want = colourOf(sb[7 - 2 * ((i % perByte) / (perByte / 4)) -: 2]);
          if (codes[i] != want) begin
            reportMismatch($sformatf("pixel %0d is %h, expected %h", i, codes[i], want));
          end
        end
      end
    end else if (kind == 3) begin
      if (dlistLoadCount - dlBase != 1 || lastDlist != opAddr) reportMismatch("bad dlistLoad");
      if (dlistEndCount - endBase != int'(instr[JvbBit])) reportMismatch("bad dlistEnd");
      if (codes.size() != 0) reportMismatch("codes emitted during jump");
    end
    if (errors == errBase) begin
      passed++;
      $display("test %0d kind %0d: ok", idx, kind);
    end else begin
      $display("test %0d kind %0d: FAILED", idx, kind);
    end
  endtask

  initial begin
    int nRec;
    int total;
    nRec = 0;
    total = 0;
    $readmemh("testbench/anticTranslate_tests.txt", tests);
    while (nRec < 16 && tests[nRec * 8] != 8'hFF) begin
      total += int'({tests[nRec * 8 + 5], tests[nRec * 8 + 6]});
      nRec++;
    end
    limitCycles = (total + nRec) * 200;
    repeat (8) @(posedge Fphi0);
    #2;
    rst = 1'b0;
    for (int t = 0; t < nRec; t++) begin
      runTest(t);
    end
    $display("%0d tests, %0d passed, %0d checks failed", nRec, passed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog sized from the expected code count
  initial begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge Fphi0);
    $display("Run timed out after %0d cycles waiting for the DUT", limitCycles);
    $display("Something failed");
    $finish;
  end

endmodule

/* testbench/anticTranslate_tests.txt */
// kind(0 apb,1 blank,2 map,3 jump) dmaCtl instr opLo opHi countHi countLo badAddr
// count is the number of non-idle codes expected from the record
00 03 00 00 00 00 00 05
01 02 00 00 00 00 80 00
01 02 20 00 00 01 80 00
02 01 4e 00 20 00 80 00
02 02 4e 34 12 00 a0 00
02 03 4e 78 56 00 c0 00
02 02 4d 00 30 01 40 00
02 00 4d 00 40 00 00 00
03 02 01 34 12 00 00 00
03 02 41 cd ab 00 00 00
ff 00 00 00 00 00 00 00
